// File: decodeStage.f
common/decodePkg.sv
design/fetchLatch.sv
design/decodeSlot/immGen.sv
design/decodeSlot/decodeSlot.sv
design/issueLatch.sv
design/decodeStage.sv
dv/decodeStage_props.sv
dv/decodeStageTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module decodeStageTb \
    -f decodeStage.f \
    --Mdir obj_dir

./obj_dir/VdecodeStageTb +verilator+error+limit+1000 | tee sim.log

if grep -qx "All tests passed!" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi

// File: dv/decodeStageTb.sv
module decodeStageTb;

    logic clk;
    logic reset;
    decodePkg::fetchBundleT fetchIn;
    decodePkg::decodedOpT issueOut [decodePkg::slotCount];
    logic issueValid;

    integer seed = 32'hc5447608;
    int testsRun = 0;
    int testsFailed = 0;
    int startFails = 0;
    int timeouts = 0;
    logic [31:0] word;

    // Register forms of the ALU and MDU groups
    localparam logic [31:0] regOpBase [18] = '{
        32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000,
        32'h0014_0000, 32'h0014_8000, 32'h0015_0000, 32'h0015_8000,
        32'h0017_0000, 32'h0017_8000, 32'h0018_0000, 32'h001c_0000,
        32'h001c_8000, 32'h001d_0000, 32'h0020_0000, 32'h0020_8000,
        32'h0021_0000, 32'h0021_8000
    };

    decodeStage decodeStage_inst (
        .clk       (clk),
        .reset     (reset),
        .fetchIn   (fetchIn),
        .issueOut  (issueOut),
        .issueValid(issueValid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] randBits(input logic [31:0] mask);
        return $random(seed) & mask;
    endfunction

    function automatic logic [31:0] regOpWord();
        logic [4:0] pick;
        pick = 5'(randBits(32'hffff_ffff) % 32'd18);
        return regOpBase[pick] | randBits(32'h0000_7fff);
    endfunction

    task automatic sendBundle(input logic [1:0] plv, input logic [31:0] i0,
                              input logic [31:0] i1, input logic [31:0] i2);
        decodePkg::fetchBundleT b;
        b.valid = 1'b1;
        b.plv = plv;
        b.slots[0].inst = i0;
        b.slots[1].inst = i1;
        b.slots[2].inst = i2;
        for (int i = 0; i < decodePkg::slotCount; i++) begin
            b.slots[i].pc = randBits(32'hffff_fffc);
        end
        @(posedge clk);
        fetchIn <= b;
    endtask

    // Drop valid, then let the last bundle come out and drain
    task automatic finishTest(input string name);
        int n;
        int fails;
        bit late;
        @(posedge clk);
        fetchIn.valid <= 1'b0;
        late = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!issueValid && n < 20);
        if (!issueValid) begin
            late = 1'b1;
        end
        n = 0;
        while (issueValid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (issueValid) begin
            late = 1'b1;
        end
        fails = decodeStage_inst.props_inst.failCount - startFails;
        testsRun++;
        if (late) begin
            timeouts++;
            testsFailed++;
            $display("test %s: timed out waiting for issueValid", name);
        end else if (fails != 0) begin
            testsFailed++;
            $display("test %s: %0d assertion failures", name, fails);
        end else begin
            $display("test %s: ok", name);
        end
        startFails = decodeStage_inst.props_inst.failCount;
    endtask

    initial begin
        reset = 1'b1;
        fetchIn = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);
        startFails = decodeStage_inst.props_inst.failCount;

        sendBundle(2'd0, 32'h0280_0000, 32'h0280_0000, 32'h0280_0000);
        finishTest("resetAndValid");
        for (int k = 0; k < 4; k++) begin
            sendBundle(2'd0, randBits(32'h0000_7fff) | 32'h0010_0000,
                       randBits(32'h0000_7fff) | 32'h0011_0000,
                       randBits(32'h0000_7fff) | 32'h0015_8000);
        end
        finishTest("backToBack");

        for (int k = 0; k < 12; k++) begin
            sendBundle(2'd0, regOpWord(), regOpWord(), regOpWord());
        end
        finishTest("registerOps");

        for (int k = 0; k < 6; k++) begin
            sendBundle(2'd0, randBits(32'h003f_ffff) | 32'h0280_0000,
                       randBits(32'h003f_ffff) | 32'h2880_0000,
                       randBits(32'h003f_ffff) | 32'h0340_0000);
            sendBundle(2'd0, randBits(32'h0000_7fff) | 32'h0040_8000,
                       randBits(32'h03ff_ffff) | 32'h4c00_0000,
                       randBits(32'h01ff_ffff) | 32'h1400_0000);
            sendBundle(2'd0, randBits(32'h01ff_ffff) | 32'h1c00_0000,
                       randBits(32'h03ff_ffff) | 32'h5400_0000,
                       randBits(32'h003f_ffff) | 32'h2a00_0000);
        end
        finishTest("immediates");

        for (int k = 0; k < 6; k++) begin
            sendBundle(2'd0, randBits(32'h003f_ffff) | 32'h2980_0000,
                       randBits(32'h03ff_ffff) | 32'h5800_0000,
                       randBits(32'h03ff_ffff) | 32'h6800_0000);
            sendBundle(2'd0, randBits(32'h003f_ffff) | 32'h2900_0000,
                       randBits(32'h003f_ffff) | 32'h2940_0000,
                       randBits(32'h03ff_ffff) | 32'h6c00_0000);
        end
        finishTest("storesAndBranches");

        // CSR word with rj in bits 9:5
        word = randBits(32'h00ff_fc1f) | 32'h0400_0000;
        sendBundle(2'd0, word, word | 32'h0000_0020, word | 32'h0000_00a0);
        sendBundle(2'd3, word, word | 32'h0000_00a0, 32'h0648_3800);
        sendBundle(2'd1, 32'h0648_3800, word | 32'h0000_0020, 32'h0280_0000);
        sendBundle(2'd0, 32'h0648_3800, word, word | 32'h0000_0020);
        finishTest("csrAndPrivilege");

        sendBundle(2'd0, randBits(32'h0000_7fff) | 32'h002a_0000,
                   randBits(32'h0000_7fff) | 32'h002b_0000, 32'h0648_8000);
        for (int k = 0; k < 4; k++) begin
            sendBundle(2'd0, randBits(32'h03ff_ffff) | 32'hfc00_0000,
                       randBits(32'h03ff_ffff) | 32'h5000_0000, 32'h3872_0000);
        end
        finishTest("exceptions");

        $display("tests run %0d, tests failed %0d, assertion failures %0d, timeouts %0d",
                 testsRun, testsFailed, decodeStage_inst.props_inst.failCount, timeouts);
        if (testsFailed == 0 && decodeStage_inst.props_inst.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/decodeStage_props.sv
module decodeStage_props (
    input logic                   clk,
    input logic                   reset,
    input decodePkg::fetchBundleT fetchIn,
    input decodePkg::decodedOpT   issueOut [decodePkg::slotCount],
    input logic                   issueValid
);

    decodePkg::fetchBundleT prev1;
    decodePkg::fetchBundleT prev2;
    decodePkg::decodedOpT expected [decodePkg::slotCount];
    int failCount = 0;

    // Reference decoder built from the ISA field layout
    function automatic decodePkg::decodedOpT refDecode(
        input logic [31:0] w,
        input logic [31:0] pc,
        input logic [1:0]  plv
    );
        decodePkg::decodedOpT e;
        decodePkg::opConfT r3;
        decodePkg::opConfT sh;
        decodePkg::opConfT i12;
        decodePkg::opConfT mem;
        decodePkg::opConfT br;
        logic [31:0] si12;
        logic [31:0] ui12;
        logic [31:0] offs;
        logic [31:0] up20;
        si12 = {{20{w[21]}}, w[21:10]};
        ui12 = {20'b0, w[21:10]};
        offs = {{14{w[25]}}, w[25:10], 2'b00};
        up20 = {w[24:5], 12'b0};
        case (w[31:15])
            17'h00020: r3 = decodePkg::confAdd;
            17'h00022: r3 = decodePkg::confSub;
            17'h00024: r3 = decodePkg::confLt;
            17'h00025: r3 = decodePkg::confLtu;
            17'h00028: r3 = decodePkg::confNor;
            17'h00029: r3 = decodePkg::confAnd;
            17'h0002a: r3 = decodePkg::confOr;
            17'h0002b: r3 = decodePkg::confXor;
            17'h0002e: r3 = decodePkg::confSll;
            17'h0002f: r3 = decodePkg::confSrl;
            17'h00030: r3 = decodePkg::confSra;
            17'h00038: r3 = decodePkg::confMul;
            17'h00039: r3 = decodePkg::confMulh;
            17'h0003a: r3 = decodePkg::confMulhu;
            17'h00040: r3 = decodePkg::confDiv;
            17'h00041: r3 = decodePkg::confMod;
            17'h00042: r3 = decodePkg::confDivu;
            17'h00043: r3 = decodePkg::confModu;
            default: r3 = decodePkg::confNone;
        endcase
        case (w[31:15])
            17'h00081: sh = decodePkg::confSll;
            17'h00089: sh = decodePkg::confSrl;
            17'h00091: sh = decodePkg::confSra;
            default: sh = decodePkg::confNone;
        endcase
        case (w[31:22])
            10'h008: i12 = decodePkg::confLt;
            10'h009: i12 = decodePkg::confLtu;
            10'h00a: i12 = decodePkg::confAdd;
            10'h00d: i12 = decodePkg::confAnd;
            10'h00e: i12 = decodePkg::confOr;
            10'h00f: i12 = decodePkg::confXor;
            default: i12 = decodePkg::confNone;
        endcase
        case (w[31:22])
            10'h0a0: mem = decodePkg::confByte;
            10'h0a1: mem = decodePkg::confHalf;
            10'h0a2: mem = decodePkg::confWord;
            10'h0a4: mem = decodePkg::confByte;
            10'h0a5: mem = decodePkg::confHalf;
            10'h0a6: mem = decodePkg::confWord;
            10'h0a8: mem = decodePkg::confByteU;
            10'h0a9: mem = decodePkg::confHalfU;
            default: mem = decodePkg::confNone;
        endcase
        case (w[31:26])
            6'h16: br = decodePkg::confEq;
            6'h17: br = decodePkg::confNe;
            6'h18: br = decodePkg::confLt;
            6'h19: br = decodePkg::confGe;
            6'h1a: br = decodePkg::confLtu;
            6'h1b: br = decodePkg::confGeu;
            default: br = decodePkg::confNone;
        endcase
        e = '0;
        e.rd = w[4:0];
        e.rj = w[9:5];
        e.regWr = 1'b1;
        if (r3 != decodePkg::confNone) begin
            e.opType = (r3 >= decodePkg::confMul) ? decodePkg::typeMdu : decodePkg::typeAlu;
            e.opConf = r3;
            e.rk = w[14:10];
        end else if (sh != decodePkg::confNone) begin
            e.opType = decodePkg::typeAlu;
            e.opConf = sh;
            e.imm = {27'b0, w[14:10]};
            e.isImm = 1'b1;
        end else if (i12 != decodePkg::confNone) begin
            e.opType = decodePkg::typeAlu;
            e.opConf = i12;
            e.isImm = 1'b1;
            // Logical immediates are zero extended
            if (i12 == decodePkg::confAnd || i12 == decodePkg::confOr
                || i12 == decodePkg::confXor) begin
                e.imm = ui12;
            end else begin
                e.imm = si12;
            end
        end else if (mem != decodePkg::confNone) begin
            e.opType = decodePkg::typeLsu;
            e.opConf = mem;
            e.imm = si12;
            e.isStore = w[24];
            e.regWr = !w[24];
        end else if (w[31:24] == 8'h04) begin
            e.opType = decodePkg::typeCsr;
            e.csrAddr = w[23:10];
            e.csrWr = w[9:5] != 5'd0;
            if (w[9:5] == 5'd0) begin
                e.opConf = decodePkg::confCsrRd;
            end else if (w[9:5] == 5'd1) begin
                e.opConf = decodePkg::confCsrWr;
            end else begin
                e.opConf = decodePkg::confCsrXchg;
            end
        end else if (w[31:25] == 7'h0a || w[31:25] == 7'h0e) begin
            e.opType = decodePkg::typeDir;
            e.rj = '0;
            e.imm = (w[31:25] == 7'h0e) ? pc + up20 : up20;
        end else if (w[31:26] == 6'h13) begin
            e.opType = decodePkg::typeJirl;
            e.imm = offs;
        end else if (w[31:26] == 6'h15) begin
            e.opType = decodePkg::typeDir;
            e.rd = 5'd1;
            e.rj = '0;
            e.imm = pc + 32'd4;
        end else if (br != decodePkg::confNone) begin
            e.opType = decodePkg::typeBru;
            e.opConf = br;
            e.imm = offs;
            e.regWr = 1'b0;
        end else if (w == 32'h0648_3800) begin
            e = '0;
            e.opType = decodePkg::typeCsr;
            e.isErtn = 1'b1;
        end else begin
            e = '0;
            e.hasExcp = 1'b1;
            if (w[31:15] == 17'h00054) begin
                e.excpCode = decodePkg::excpBrk;
            end else if (w[31:15] == 17'h00056) begin
                e.excpCode = decodePkg::excpSys;
            end else begin
                e.excpCode = decodePkg::excpIne;
            end
        end
        if (e.opType == decodePkg::typeCsr && plv != 2'b00) begin
            e.hasExcp = 1'b1;
            e.excpCode = decodePkg::excpIpe;
        end
        return e;
    endfunction

    // Two-deep copy of the input, matching the stage latency
    always_ff @(posedge clk) begin
        prev1 <= fetchIn;
        prev2 <= prev1;
    end

    resetIdle: assert property (@(posedge clk) reset |=> !issueValid)
        else begin
            $error("issueValid went high right after a reset cycle");
            failCount++;
        end

    validTiming: assert property (@(posedge clk) disable iff (reset)
        issueValid == prev2.valid)
        else begin
            $error("MISMATCH issueValid got %h exp %h", $sampled(issueValid),
                   $sampled(prev2.valid));
            failCount++;
        end

    for (genvar i = 0; i < decodePkg::slotCount; i++) begin : slotChk
        assign expected[i] = refDecode(prev2.slots[i].inst, prev2.slots[i].pc, prev2.plv);

        decodeMatch: assert property (@(posedge clk) disable iff (reset)
            issueValid |-> issueOut[i] == expected[i])
            else begin
                $error("MISMATCH issueOut[%0d] got %h exp %h", i, $sampled(issueOut[i]),
                       $sampled(expected[i]));
                failCount++;
            end
    end

endmodule

bind decodeStage decodeStage_props props_inst (.*);

// File: design/decodeStage.sv
module decodeStage (
    input  logic                   clk,
    input  logic                   reset,
    input  decodePkg::fetchBundleT fetchIn,
    output decodePkg::decodedOpT   issueOut [decodePkg::slotCount],
    output logic                   issueValid
);

    decodePkg::fetchBundleT latchedBundle;
    decodePkg::decodedOpT decoded [decodePkg::slotCount];

    fetchLatch fetchLatch_inst (
        .clk          (clk),
        .reset        (reset),
        .fetchIn      (fetchIn),
        .latchedBundle(latchedBundle)
    );

    // Slots decode in parallel and share the privilege level
    for (genvar i = 0; i < decodePkg::slotCount; i++) begin : slotGen
        decodeSlot decodeSlot_inst (
            .slotIn   (latchedBundle.slots[i]),
            .plv      (latchedBundle.plv),
            .decodedOp(decoded[i])
        );
    end

    issueLatch issueLatch_inst (
        .clk       (clk),
        .reset     (reset),
        .valid     (latchedBundle.valid),
        .decodedIn (decoded),
        .issueOut  (issueOut),
        .issueValid(issueValid)
    );

endmodule

// File: design/issueLatch.sv
module issueLatch (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  decodePkg::decodedOpT decodedIn [decodePkg::slotCount],
    output decodePkg::decodedOpT issueOut [decodePkg::slotCount],
    output logic                 issueValid
);

    always_ff @(posedge clk) begin
        if (reset) begin
            issueValid <= 1'b0;
            issueOut <= '{default: '0};
        end else begin
            issueValid <= valid;
            // Hold the last bundle on idle cycles
            if (valid) begin
                issueOut <= decodedIn;
            end
        end
    end

endmodule

// File: design/decodeSlot/decodeSlot.sv
module decodeSlot (
    input  decodePkg::fetchSlotT slotIn,
    input  logic [1:0]           plv,
    output decodePkg::decodedOpT decodedOp
);

    typedef struct packed {
        decodePkg::patT pat;
        decodePkg::opTypeT opType;
        decodePkg::opConfT opConf;
        decodePkg::immFmtT immFmt;
    } ruleT;

    localparam int ruleCount = 46;

    // Priority order, first hit wins
    localparam ruleT rules [ruleCount] = '{
        '{decodePkg::patAdd, decodePkg::typeAlu, decodePkg::confAdd, decodePkg::immNone},
        '{decodePkg::patSub, decodePkg::typeAlu, decodePkg::confSub, decodePkg::immNone},
        '{decodePkg::patSlt, decodePkg::typeAlu, decodePkg::confLt, decodePkg::immNone},
        '{decodePkg::patSltu, decodePkg::typeAlu, decodePkg::confLtu, decodePkg::immNone},
        '{decodePkg::patNor, decodePkg::typeAlu, decodePkg::confNor, decodePkg::immNone},
        '{decodePkg::patAnd, decodePkg::typeAlu, decodePkg::confAnd, decodePkg::immNone},
        '{decodePkg::patOr, decodePkg::typeAlu, decodePkg::confOr, decodePkg::immNone},
        '{decodePkg::patXor, decodePkg::typeAlu, decodePkg::confXor, decodePkg::immNone},
        '{decodePkg::patSll, decodePkg::typeAlu, decodePkg::confSll, decodePkg::immNone},
        '{decodePkg::patSrl, decodePkg::typeAlu, decodePkg::confSrl, decodePkg::immNone},
        '{decodePkg::patSra, decodePkg::typeAlu, decodePkg::confSra, decodePkg::immNone},
        '{decodePkg::patMul, decodePkg::typeMdu, decodePkg::confMul, decodePkg::immNone},
        '{decodePkg::patMulh, decodePkg::typeMdu, decodePkg::confMulh, decodePkg::immNone},
        '{decodePkg::patMulhu, decodePkg::typeMdu, decodePkg::confMulhu, decodePkg::immNone},
        '{decodePkg::patDiv, decodePkg::typeMdu, decodePkg::confDiv, decodePkg::immNone},
        '{decodePkg::patMod, decodePkg::typeMdu, decodePkg::confMod, decodePkg::immNone},
        '{decodePkg::patDivu, decodePkg::typeMdu, decodePkg::confDivu, decodePkg::immNone},
        '{decodePkg::patModu, decodePkg::typeMdu, decodePkg::confModu, decodePkg::immNone},
        '{decodePkg::patSlli, decodePkg::typeAlu, decodePkg::confSll, decodePkg::immUi5},
        '{decodePkg::patSrli, decodePkg::typeAlu, decodePkg::confSrl, decodePkg::immUi5},
        '{decodePkg::patSrai, decodePkg::typeAlu, decodePkg::confSra, decodePkg::immUi5},
        '{decodePkg::patSlti, decodePkg::typeAlu, decodePkg::confLt, decodePkg::immSi12},
        '{decodePkg::patSltui, decodePkg::typeAlu, decodePkg::confLtu, decodePkg::immSi12},
        '{decodePkg::patAddi, decodePkg::typeAlu, decodePkg::confAdd, decodePkg::immSi12},
        '{decodePkg::patAndi, decodePkg::typeAlu, decodePkg::confAnd, decodePkg::immUi12},
        '{decodePkg::patOri, decodePkg::typeAlu, decodePkg::confOr, decodePkg::immUi12},
        '{decodePkg::patXori, decodePkg::typeAlu, decodePkg::confXor, decodePkg::immUi12},
        '{decodePkg::patCsr, decodePkg::typeCsr, decodePkg::confCsrRd, decodePkg::immNone},
        '{decodePkg::patLu12i, decodePkg::typeDir, decodePkg::confNone, decodePkg::immUp20},
        '{decodePkg::patPcaddu12i, decodePkg::typeDir, decodePkg::confNone, decodePkg::immPcUp20},
        '{decodePkg::patLdb, decodePkg::typeLsu, decodePkg::confByte, decodePkg::immSi12},
        '{decodePkg::patLdh, decodePkg::typeLsu, decodePkg::confHalf, decodePkg::immSi12},
        '{decodePkg::patLdw, decodePkg::typeLsu, decodePkg::confWord, decodePkg::immSi12},
        '{decodePkg::patStb, decodePkg::typeLsu, decodePkg::confByte, decodePkg::immSi12},
        '{decodePkg::patSth, decodePkg::typeLsu, decodePkg::confHalf, decodePkg::immSi12},
        '{decodePkg::patStw, decodePkg::typeLsu, decodePkg::confWord, decodePkg::immSi12},
        '{decodePkg::patLdbu, decodePkg::typeLsu, decodePkg::confByteU, decodePkg::immSi12},
        '{decodePkg::patLdhu, decodePkg::typeLsu, decodePkg::confHalfU, decodePkg::immSi12},
        '{decodePkg::patJirl, decodePkg::typeJirl, decodePkg::confNone, decodePkg::immOffs16},
        '{decodePkg::patBl, decodePkg::typeDir, decodePkg::confNone, decodePkg::immPcPlus4},
        '{decodePkg::patBeq, decodePkg::typeBru, decodePkg::confEq, decodePkg::immOffs16},
        '{decodePkg::patBne, decodePkg::typeBru, decodePkg::confNe, decodePkg::immOffs16},
        '{decodePkg::patBlt, decodePkg::typeBru, decodePkg::confLt, decodePkg::immOffs16},
        '{decodePkg::patBge, decodePkg::typeBru, decodePkg::confGe, decodePkg::immOffs16},
        '{decodePkg::patBltu, decodePkg::typeBru, decodePkg::confLtu, decodePkg::immOffs16},
        '{decodePkg::patBgeu, decodePkg::typeBru, decodePkg::confGeu, decodePkg::immOffs16}
    };

    logic [decodePkg::xlen-1:0] inst;
    logic [decodePkg::xlen-1:0] imm;
    logic [decodePkg::regIdxWidth-1:0] rjField;
    logic found;
    ruleT rule;

    function automatic logic hit(input logic [decodePkg::xlen-1:0] word,
                                 input decodePkg::patT pat);
        return (word & pat.mask) == pat.match;
    endfunction

    assign inst = slotIn.inst;
    assign rjField = inst[9:5];

    always_comb begin
        found = 1'b0;
        rule = '0;
        for (int i = 0; i < ruleCount; i++) begin
            if (!found && hit(inst, rules[i].pat)) begin
                found = 1'b1;
                rule = rules[i];
            end
        end
    end

    immGen immGen_inst (
        .inst  (inst),
        .pc    (slotIn.pc),
        .immFmt(rule.immFmt),
        .imm   (imm)
    );

    always_comb begin
        decodedOp = '0;
        if (hit(inst, decodePkg::patBreak)) begin
            decodedOp.hasExcp = 1'b1;
            decodedOp.excpCode = decodePkg::excpBrk;
        end else if (hit(inst, decodePkg::patSyscall)) begin
            decodedOp.hasExcp = 1'b1;
            decodedOp.excpCode = decodePkg::excpSys;
        end else if (hit(inst, decodePkg::patErtn)) begin
            decodedOp.opType = decodePkg::typeCsr;
            decodedOp.isErtn = 1'b1;
        end else if (!found) begin
            decodedOp.hasExcp = 1'b1;
            decodedOp.excpCode = decodePkg::excpIne;
        end else begin
            decodedOp.opType = rule.opType;
            decodedOp.opConf = rule.opConf;
            decodedOp.imm = imm;
            // BL links through r1
            decodedOp.rd = (rule.immFmt == decodePkg::immPcPlus4) ? 5'd1 : inst[4:0];
            decodedOp.rj = (rule.opType == decodePkg::typeDir) ? '0 : rjField;
            if (rule.immFmt == decodePkg::immNone && rule.opType != decodePkg::typeCsr) begin
                decodedOp.rk = inst[14:10];
            end
            decodedOp.isImm = rule.opType == decodePkg::typeAlu
                              && rule.immFmt != decodePkg::immNone;
            // Bit 24 splits stores from loads
            decodedOp.isStore = rule.opType == decodePkg::typeLsu && inst[24];
            decodedOp.regWr = rule.opType != decodePkg::typeBru && !decodedOp.isStore;
            if (rule.opType == decodePkg::typeCsr) begin
                decodedOp.csrAddr = inst[23:10];
                decodedOp.csrWr = rjField != '0;
                if (rjField == 5'd0) begin
                    decodedOp.opConf = decodePkg::confCsrRd;
                end else if (rjField == 5'd1) begin
                    decodedOp.opConf = decodePkg::confCsrWr;
                end else begin
                    decodedOp.opConf = decodePkg::confCsrXchg;
                end
            end
        end
        // CSR access and ERTN need kernel level
        if (decodedOp.opType == decodePkg::typeCsr && plv != 2'b00) begin
            decodedOp.hasExcp = 1'b1;
            decodedOp.excpCode = decodePkg::excpIpe;
        end
    end

endmodule

// File: design/decodeSlot/immGen.sv
module immGen (
    input  logic [decodePkg::xlen-1:0] inst,
    input  logic [decodePkg::xlen-1:0] pc,
    input  decodePkg::immFmtT          immFmt,
    output logic [decodePkg::xlen-1:0] imm
);

    logic [decodePkg::xlen-1:0] upper20;

    assign upper20 = {inst[24:5], 12'b0};

    always_comb begin
        case (immFmt)
            decodePkg::immSi12: imm = {{20{inst[21]}}, inst[21:10]};
            decodePkg::immUi12: imm = {20'b0, inst[21:10]};
            decodePkg::immUi5: imm = {27'b0, inst[14:10]};
            // offs16 counts words
            decodePkg::immOffs16: imm = {{14{inst[25]}}, inst[25:10], 2'b00};
            decodePkg::immUp20: imm = upper20;
            decodePkg::immPcUp20: imm = pc + upper20;
            decodePkg::immPcPlus4: imm = pc + 32'd4;
            default: imm = '0;
        endcase
    end

endmodule

// File: design/fetchLatch.sv
module fetchLatch (
    input  logic                   clk,
    input  logic                   reset,
    input  decodePkg::fetchBundleT fetchIn,
    output decodePkg::fetchBundleT latchedBundle
);

    always_ff @(posedge clk) begin
        if (reset) begin
            latchedBundle.valid <= 1'b0;
        end else begin
            latchedBundle.valid <= fetchIn.valid;
        end
        // Words stay put across idle cycles
        if (fetchIn.valid) begin
            latchedBundle.plv <= fetchIn.plv;
            latchedBundle.slots <= fetchIn.slots;
        end
    end

endmodule

// File: common/decodePkg.sv
package decodePkg;

    localparam int xlen = 32;
    localparam int slotCount = 3;
    localparam int regIdxWidth = 5;
    localparam int csrAddrWidth = 14;

    typedef struct packed {
        logic [xlen-1:0] match;
        logic [xlen-1:0] mask;
    } patT;

    // Care masks by encoding format
    localparam logic [xlen-1:0] maskR3 = 32'hffff_8000;
    localparam logic [xlen-1:0] maskI12 = 32'hffc0_0000;
    localparam logic [xlen-1:0] maskI20 = 32'hfe00_0000;
    localparam logic [xlen-1:0] maskI26 = 32'hfc00_0000;
    localparam logic [xlen-1:0] maskCsr = 32'hff00_0000;
    localparam logic [xlen-1:0] maskFull = 32'hffff_ffff;

    localparam patT patAdd = '{32'h0010_0000, maskR3};
    localparam patT patSub = '{32'h0011_0000, maskR3};
    localparam patT patSlt = '{32'h0012_0000, maskR3};
    localparam patT patSltu = '{32'h0012_8000, maskR3};
    localparam patT patNor = '{32'h0014_0000, maskR3};
    localparam patT patAnd = '{32'h0014_8000, maskR3};
    localparam patT patOr = '{32'h0015_0000, maskR3};
    localparam patT patXor = '{32'h0015_8000, maskR3};
    localparam patT patSll = '{32'h0017_0000, maskR3};
    localparam patT patSrl = '{32'h0017_8000, maskR3};
    localparam patT patSra = '{32'h0018_0000, maskR3};
    localparam patT patMul = '{32'h001c_0000, maskR3};
    localparam patT patMulh = '{32'h001c_8000, maskR3};
    localparam patT patMulhu = '{32'h001d_0000, maskR3};
    localparam patT patDiv = '{32'h0020_0000, maskR3};
    localparam patT patMod = '{32'h0020_8000, maskR3};
    localparam patT patDivu = '{32'h0021_0000, maskR3};
    localparam patT patModu = '{32'h0021_8000, maskR3};
    localparam patT patBreak = '{32'h002a_0000, maskR3};
    localparam patT patSyscall = '{32'h002b_0000, maskR3};
    localparam patT patSlli = '{32'h0040_8000, maskR3};
    localparam patT patSrli = '{32'h0044_8000, maskR3};
    localparam patT patSrai = '{32'h0048_8000, maskR3};
    localparam patT patSlti = '{32'h0200_0000, maskI12};
    localparam patT patSltui = '{32'h0240_0000, maskI12};
    localparam patT patAddi = '{32'h0280_0000, maskI12};
    localparam patT patAndi = '{32'h0340_0000, maskI12};
    localparam patT patOri = '{32'h0380_0000, maskI12};
    localparam patT patXori = '{32'h03c0_0000, maskI12};
    localparam patT patCsr = '{32'h0400_0000, maskCsr};
    localparam patT patErtn = '{32'h0648_3800, maskFull};
    localparam patT patLu12i = '{32'h1400_0000, maskI20};
    localparam patT patPcaddu12i = '{32'h1c00_0000, maskI20};
    localparam patT patLdb = '{32'h2800_0000, maskI12};
    localparam patT patLdh = '{32'h2840_0000, maskI12};
    localparam patT patLdw = '{32'h2880_0000, maskI12};
    localparam patT patStb = '{32'h2900_0000, maskI12};
    localparam patT patSth = '{32'h2940_0000, maskI12};
    localparam patT patStw = '{32'h2980_0000, maskI12};
    localparam patT patLdbu = '{32'h2a00_0000, maskI12};
    localparam patT patLdhu = '{32'h2a40_0000, maskI12};
    localparam patT patJirl = '{32'h4c00_0000, maskI26};
    localparam patT patBl = '{32'h5400_0000, maskI26};
    localparam patT patBeq = '{32'h5800_0000, maskI26};
    localparam patT patBne = '{32'h5c00_0000, maskI26};
    localparam patT patBlt = '{32'h6000_0000, maskI26};
    localparam patT patBge = '{32'h6400_0000, maskI26};
    localparam patT patBltu = '{32'h6800_0000, maskI26};
    localparam patT patBgeu = '{32'h6c00_0000, maskI26};

    typedef enum logic [2:0] {
        immNone, immSi12, immUi12, immUi5, immOffs16, immUp20, immPcUp20, immPcPlus4
    } immFmtT;

    typedef enum logic [2:0] {
        typeNone, typeAlu, typeMdu, typeLsu, typeBru, typeJirl, typeDir, typeCsr
    } opTypeT;

    // Compare ops lt and ltu are shared by SLT and the branches
    typedef enum logic [4:0] {
        confNone,
        confAdd, confSub, confLt, confLtu, confNor, confAnd, confOr, confXor,
        confSll, confSrl, confSra,
        confMul, confMulh, confMulhu, confDiv, confDivu, confMod, confModu,
        confByte, confHalf, confWord, confByteU, confHalfU,
        confEq, confNe, confGe, confGeu,
        confCsrRd, confCsrWr, confCsrXchg
    } opConfT;

    typedef enum logic [4:0] {
        excpNone = 5'h00,
        excpSys = 5'h0b,
        excpBrk = 5'h0c,
        excpIne = 5'h0d,
        excpIpe = 5'h0e
    } excpCodeT;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetchSlotT;

    typedef struct packed {
        logic valid;
        logic [1:0] plv;
        fetchSlotT [slotCount-1:0] slots;
    } fetchBundleT;

    typedef struct packed {
        logic [regIdxWidth-1:0] rj;
        logic [regIdxWidth-1:0] rk;
        logic [regIdxWidth-1:0] rd;
        logic [xlen-1:0] imm;
        opTypeT opType;
        opConfT opConf;
        logic isImm;
        logic regWr;
        logic isStore;
        logic hasExcp;
        excpCodeT excpCode;
        logic [csrAddrWidth-1:0] csrAddr;
        logic csrWr;
        logic isErtn;
    } decodedOpT;

endpackage
